// ==== verif/frontend_patterns.txt ====
// @00 memory image by word index, @80 retire indices that raise irq, ended by ffffffff
// @88 number of expected retires, @90 expected retires as pc cause next
@00
00000000 00000000 10000008 f0000000  // 000 seq seq b+8 skipped
3000a005 2000000c f0000000 f0000000  // 010 cmp 5,5 bf+12 skipped skipped
3000a006 20000040 40000000 00000000  // 020 cmp 5,6 bf not taken syscall seq
00000000 30002001 f0000000           // 030 seq cmp 1,1 illegal
@40
20000040 00000000 50000000           // 100 handler bf+64 seq ertn
@50
10000002                             // 140 b+2 to a misaligned pc
@80
00000007 00000010 ffffffff
@88
0000001b
@90
000 3f 004  004 3f 008  008 3f 010
010 3f 014  014 3f 020  020 3f 024
024 3f 028  028 0b 100  100 3f 104
104 3f 108  108 3f 02c  02c 00 100
100 3f 104  104 3f 108  108 3f 02c
02c 3f 030  030 3f 034  034 00 100
100 3f 104  104 3f 108  108 3f 034
034 3f 038  038 0d 100  100 3f 140
140 3f 142  142 08 100  100 3f 140

// ==== frontend.f ====
source/fe_pkg.sv
source/fe_if.sv
source/pc_reg.sv
source/fetch_port.sv
source/inst_decode.sv
source/branch_execute.sv
source/commit_result.sv
source/frontend_top.sv
verif/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module frontend_tb \
    -f frontend.f -o frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/frontend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verif/frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb
    import fe_pkg::*;
();

    localparam addr_t RESET_PC  = 32'h0000_0000;
    localparam addr_t EXC_ENTRY = 32'h0000_0100;

    // patterns file layout, word indices
    localparam int PAT_WORDS   = 256;
    localparam int MEM_WORDS   = 128;
    localparam int IRQ_BASE    = 'h80;
    localparam int IRQ_SLOTS   = 8;
    localparam int COUNT_AT    = 'h88;
    localparam int EXP_BASE    = 'h90;
    localparam int MAX_RETIRES = (PAT_WORDS - EXP_BASE) / 3;
    // cycles allowed between two retires
    localparam int TIMEOUT     = 200;

    logic   clk        = 1'b0;
    logic   rst        = 1'b1;
    logic   irq        = 1'b0;
    logic   fetch_ack  = 1'b0;
    inst_t  fetch_data = '0;
    logic   fetch_req;
    addr_t  fetch_addr;
    logic   retire_valid;
    addr_t  retire_pc;
    cause_t retire_cause;
    addr_t  retire_next;

    // memory image, irq points and expected trace in one array
    logic [31:0] pat [0:PAT_WORDS-1];

    integer seed     = 11;
    int     ack_wait = -1;
    int     errors   = 0;
    int     checks   = 0;
    logic   req_seen = 1'b0;
    addr_t  next_fetch = RESET_PC;

    frontend_top #(
        .RESET_PC  (RESET_PC),
        .EXC_ENTRY (EXC_ENTRY)
    ) frontend_top_i (
        .clk          (clk),
        .rst          (rst),
        .irq          (irq),
        .fetch_ack    (fetch_ack),
        .fetch_data   (fetch_data),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_cause (retire_cause),
        .retire_next  (retire_next)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // memory responder
    //////////////////////////////////////////////////////////////////////

    // word at a byte address, outside the image a fill is returned
    function automatic inst_t mem_word(input addr_t addr);
        int w;
        w = int'(addr[31:2]);
        if (w < MEM_WORDS) begin
            return pat[w];
        end
        return 32'hF000_0000 ^ addr;
    endfunction

    // four-phase slave, random ack delay of 0 to 5 cycles
    always @(posedge clk) begin
        #1;
        if (rst) begin
            fetch_ack = 1'b0;
            ack_wait  = -1;
        end else if (fetch_req && !fetch_ack) begin
            if (ack_wait < 0) begin
                ack_wait = $unsigned($random(seed)) % 6;
            end
            if (ack_wait == 0) begin
                fetch_data = mem_word(fetch_addr);
                fetch_ack  = 1'b1;
                ack_wait   = -1;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end else if (fetch_ack && !fetch_req) begin
            // phase 4, release ack once req is gone
            fetch_ack = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input int idx,
                               input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s at retire %0d: got %h expected %h", name, idx, got, want);
        end
    endtask

    // a new request must target the last retire's next address
    task automatic watch_fetch(input int idx);
        if (fetch_req && !req_seen) begin
            check_value("fetch_addr", idx, fetch_addr, next_fetch);
            // misaligned pcs never reach the memory
            check_value("fetch_addr[1:0]", idx, {30'b0, fetch_addr[1:0]}, 32'h0);
        end
        req_seen = fetch_req;
    endtask

    // sampled at the falling edge, away from the DUT's updates
    task automatic wait_retire(input int idx, output bit got);
        int n;
        got = 1'b0;
        n   = 0;
        while (!got && n < TIMEOUT) begin
            @(negedge clk);
            watch_fetch(idx);
            got = retire_valid;
            n++;
        end
    endtask

    task automatic check_retire(input int idx);
        int base;
        base = EXP_BASE + 3 * idx;
        check_value("retire_pc", idx, retire_pc, pat[base]);
        check_value("retire_cause", idx, {26'b0, retire_cause}, pat[base + 1]);
        check_value("retire_next", idx, retire_next, pat[base + 2]);
    endtask

    // irq list ends at the first all-ones word
    function automatic bit irq_point(input int idx);
        bit hit;
        hit = 1'b0;
        for (int k = 0; k < IRQ_SLOTS; k++) begin
            if (pat[IRQ_BASE + k] == 32'hFFFF_FFFF) begin
                break;
            end
            if (pat[IRQ_BASE + k] == idx) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int count;
        int idx;
        int base;
        bit got;
        for (int i = 0; i < PAT_WORDS; i++) begin
            pat[i] = 32'hF000_0000 | i;
        end
        $readmemh("verif/frontend_patterns.txt", pat);
        count = pat[COUNT_AT];
        if (count < 1 || count > MAX_RETIRES) begin
            $display("patterns file holds no usable retire count");
            errors++;
            count = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        idx = 0;
        while (idx < count) begin
            wait_retire(idx, got);
            if (!got) begin
                $display("retire strobe never arrived for entry %0d", idx);
                errors++;
                break;
            end
            check_retire(idx);
            base       = EXP_BASE + 3 * idx;
            next_fetch = pat[base + 2];
            @(posedge clk);
            #1;
            // interrupt taken drops irq, listed retires raise it
            if (pat[base + 1] == {26'b0, CAUSE_INT}) begin
                irq = 1'b0;
            end else if (irq_point(idx)) begin
                irq = 1'b1;
            end
            idx++;
        end
        $display("checks %0d errors %0d retired %0d of %0d", checks, errors, idx, count);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== source/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top
    import fe_pkg::*;
#(
    parameter addr_t RESET_PC  = 32'h0000_0000,
    parameter addr_t EXC_ENTRY = 32'h0000_0100
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   irq,
    input  logic   fetch_ack,
    input  inst_t  fetch_data,
    output logic   fetch_req,
    output addr_t  fetch_addr,
    output logic   retire_valid,
    output addr_t  retire_pc,
    output cause_t retire_cause,
    output addr_t  retire_next
);

    //////////////////////////////////////////////////////////////////////
    // stage links
    //////////////////////////////////////////////////////////////////////

    // pc_reg to fetch_port
    logic   issue;
    addr_t  issue_pc;
    cause_t issue_cause;

    // fetch_port to inst_decode
    logic   fetched_valid;
    addr_t  fetched_pc;
    inst_t  fetched_inst;
    cause_t fetched_cause;

    // commit_result back to pc_reg
    logic   irq_en;
    logic   redirect_valid;
    addr_t  redirect_pc;

    dec_if dec_bus ();
    exe_if exe_bus ();

    pc_reg #(
        .RESET_PC (RESET_PC)
    ) pc_reg_i (
        .clk            (clk),
        .rst            (rst),
        .irq            (irq),
        .irq_en         (irq_en),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .issue          (issue),
        .issue_pc       (issue_pc),
        .issue_cause    (issue_cause)
    );

    fetch_port fetch_port_i (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .issue_pc      (issue_pc),
        .issue_cause   (issue_cause),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_ack     (fetch_ack),
        .fetch_data    (fetch_data),
        .fetched_valid (fetched_valid),
        .fetched_pc    (fetched_pc),
        .fetched_inst  (fetched_inst),
        .fetched_cause (fetched_cause)
    );

    inst_decode inst_decode_i (
        .clk           (clk),
        .rst           (rst),
        .fetched_valid (fetched_valid),
        .fetched_pc    (fetched_pc),
        .fetched_inst  (fetched_inst),
        .fetched_cause (fetched_cause),
        .dec           (dec_bus.src)
    );

    branch_execute branch_execute_i (
        .clk (clk),
        .rst (rst),
        .dec (dec_bus.dst),
        .exe (exe_bus.src)
    );

    commit_result #(
        .EXC_ENTRY (EXC_ENTRY)
    ) commit_result_i (
        .clk            (clk),
        .rst            (rst),
        .exe            (exe_bus.dst),
        .irq_en         (irq_en),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_cause   (retire_cause),
        .retire_next    (retire_next)
    );

endmodule

// ==== source/commit_result.sv ====
`timescale 1ns/1ps

module commit_result
    import fe_pkg::*;
#(
    parameter addr_t EXC_ENTRY = 32'h0000_0100
) (
    input  logic   clk,
    input  logic   rst,
    exe_if.dst     exe,
    output logic   irq_en,
    output logic   redirect_valid,
    output addr_t  redirect_pc,
    output logic   retire_valid,
    output addr_t  retire_pc,
    output cause_t retire_cause,
    output addr_t  retire_next
);

    // saved return address
    addr_t  era;
    // cause of the exception being handled
    // NONE outside a handler
    cause_t ecause;
    // first cycle out of reset
    logic   boot;

    //////////////////////////////////////////////////////////////////////
    // exception state and strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            boot           <= 1'b1;
            irq_en         <= 1'b0;
            ecause         <= CAUSE_NONE;
            redirect_valid <= 1'b0;
            retire_valid   <= 1'b0;
        end else begin
            boot           <= 1'b0;
            redirect_valid <= exe.valid;
            retire_valid   <= exe.valid;
            // interrupts open one cycle after reset
            if (boot) begin
                irq_en <= 1'b1;
            end
            if (exe.valid) begin
                if (exe.cause != CAUSE_NONE) begin
                    ecause <= exe.cause;
                    irq_en <= 1'b0;
                end else if (exe.is_ertn) begin
                    ecause <= CAUSE_NONE;
                    irq_en <= 1'b1;
                end
            end
        end
    end

    // return address and trace payload
    always_ff @(posedge clk) begin
        if (exe.valid) begin
            retire_pc    <= exe.pc;
            retire_cause <= exe.cause;
            if (exe.cause != CAUSE_NONE) begin
                // syscall resumes past itself while other faults retry
                era         <= (exe.cause == CAUSE_SYS) ? exe.pc + 32'd4 : exe.pc;
                redirect_pc <= EXC_ENTRY;
            end else if (exe.is_ertn) begin
                redirect_pc <= era;
            end else begin
                redirect_pc <= exe.next_pc;
            end
        end
    end

    // trace reports the address fetched next
    assign retire_next = redirect_pc;

    a_retire_redirect: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> redirect_valid)
        else $error("retire without redirect");

    // no interrupt reaches retire while a handler is running
    a_handler_masked: assert property (@(posedge clk) disable iff (rst)
        exe.valid && exe.cause == CAUSE_INT |-> ecause == CAUSE_NONE)
        else $error("interrupt taken inside an exception handler");

endmodule

// ==== source/branch_execute.sv ====
`timescale 1ns/1ps

module branch_execute
    import fe_pkg::*;
(
    input  logic clk,
    input  logic rst,
    dec_if.dst   dec,
    exe_if.src   exe
);

    // result of the last compare
    logic   flag;

    logic   taken;
    addr_t  target;
    addr_t  seq_pc;
    addr_t  next_pc;
    cause_t cause;

    //////////////////////////////////////////////////////////////////////
    // branch resolution
    //////////////////////////////////////////////////////////////////////

    assign taken   = (dec.op == OP_B) || (dec.op == OP_BF && flag);
    assign target  = dec.pc + dec.offset;
    assign seq_pc  = dec.pc + 32'd4;
    assign next_pc = taken ? target : seq_pc;

    // fetch-time cause first, then decode faults
    always_comb begin
        if (dec.pre_cause != CAUSE_NONE) begin
            cause = dec.pre_cause;
        end else if (dec.op == OP_SYSCALL) begin
            cause = CAUSE_SYS;
        end else if (dec.op == OP_ILL) begin
            cause = CAUSE_INE;
        end else begin
            cause = CAUSE_NONE;
        end
    end

    // compare flag and valid strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            flag      <= 1'b0;
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= dec.valid;
            if (dec.valid && dec.op == OP_CMP) begin
                flag <= (dec.cmp_a == dec.cmp_b);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            exe.pc      <= dec.pc;
            exe.next_pc <= next_pc;
            exe.cause   <= cause;
            exe.is_ertn <= (dec.op == OP_ERTN);
        end
    end

endmodule

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode
    import fe_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   fetched_valid,
    input  addr_t  fetched_pc,
    input  inst_t  fetched_inst,
    input  cause_t fetched_cause,
    dec_if.src     dec
);

    // opcode field to operation, unknown codes are illegal
    function automatic op_t decode_op(input opc_t opc);
        op_t op;
        case (opc)
            4'h0:    op = OP_SEQ;
            4'h1:    op = OP_B;
            4'h2:    op = OP_BF;
            4'h3:    op = OP_CMP;
            4'h4:    op = OP_SYSCALL;
            4'h5:    op = OP_ERTN;
            default: op = OP_ILL;
        endcase
        return op;
    endfunction

    opc_t  opc;
    addr_t offset_ext;
    op_t   op_dec;

    assign opc        = fetched_inst[31:28];
    // 26-bit byte offset, sign extended
    assign offset_ext = {{6{fetched_inst[25]}}, fetched_inst[25:0]};

    // an unfetched word carries no real operation
    assign op_dec = (fetched_cause != CAUSE_NONE) ? OP_SEQ : decode_op(opc);

    //////////////////////////////////////////////////////////////////////
    // decode register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= fetched_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetched_valid) begin
            dec.pc        <= fetched_pc;
            dec.op        <= op_dec;
            dec.offset    <= offset_ext;
            // compare operands share the offset bits
            dec.cmp_a     <= fetched_inst[25:13];
            dec.cmp_b     <= fetched_inst[12:0];
            dec.pre_cause <= fetched_cause;
        end
    end

endmodule

// ==== source/fetch_port.sv ====
`timescale 1ns/1ps

module fetch_port
    import fe_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   issue,
    input  addr_t  issue_pc,
    input  cause_t issue_cause,
    output logic   fetch_req,
    output addr_t  fetch_addr,
    input  logic   fetch_ack,
    input  inst_t  fetch_data,
    output logic   fetched_valid,
    output addr_t  fetched_pc,
    output inst_t  fetched_inst,
    output cause_t fetched_cause
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT_LOW, SKIP} state_t;

    state_t state;

    // issue that lands while ack is still high from the last word
    logic   pend;
    addr_t  pend_pc;
    cause_t pend_cause;

    logic   take;
    addr_t  take_pc;
    cause_t take_cause;

    assign take       = issue || pend;
    assign take_pc    = pend ? pend_pc : issue_pc;
    assign take_cause = pend ? pend_cause : issue_cause;

    //////////////////////////////////////////////////////////////////////
    // four-phase master
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            fetch_req     <= 1'b0;
            fetched_valid <= 1'b0;
            pend          <= 1'b0;
        end else begin
            fetched_valid <= 1'b0;
            if (issue && state != IDLE) begin
                pend <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (take) begin
                        pend <= 1'b0;
                        // pre-caused word bypasses the memory
                        if (take_cause != CAUSE_NONE) begin
                            fetched_valid <= 1'b1;
                            state         <= SKIP;
                        end else begin
                            fetch_req <= 1'b1;
                            state     <= REQ;
                        end
                    end
                end
                REQ: begin
                    // data valid with ack, drop req
                    if (fetch_ack) begin
                        fetch_req     <= 1'b0;
                        fetched_valid <= 1'b1;
                        state         <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    // no new req until ack is back low
                    if (!fetch_ack) begin
                        state <= IDLE;
                    end
                end
                SKIP: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // address and word capture
    always_ff @(posedge clk) begin
        if (issue && state != IDLE) begin
            pend_pc    <= issue_pc;
            pend_cause <= issue_cause;
        end
        if (state == IDLE && take) begin
            fetch_addr    <= take_pc;
            fetched_pc    <= take_pc;
            fetched_cause <= take_cause;
            fetched_inst  <= '0;
        end else if (state == REQ && fetch_ack) begin
            fetched_inst <= fetch_data;
        end
    end

    // memory may look at the address for the whole req phase
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        fetch_req |=> !fetch_req || $stable(fetch_addr))
        else $error("fetch_addr changed while fetch_req was high");

endmodule

// ==== source/pc_reg.sv ====
`timescale 1ns/1ps

module pc_reg
    import fe_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   irq,
    input  logic   irq_en,
    input  logic   redirect_valid,
    input  addr_t  redirect_pc,
    output logic   issue,
    output addr_t  issue_pc,
    output cause_t issue_cause
);

    // current fetch address
    addr_t pc;
    // instruction in flight, waits for its redirect
    logic  busy;

    //////////////////////////////////////////////////////////////////////
    // address and issue interlock
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= RESET_PC;
            busy  <= 1'b0;
            issue <= 1'b0;
        end else begin
            // first issue right after reset, later ones after each redirect
            issue <= !issue && (!busy || redirect_valid);
            if (issue) begin
                busy <= 1'b1;
            end else if (redirect_valid) begin
                busy <= 1'b0;
            end
            // every retire redirects, so no sequential increment here
            if (redirect_valid) begin
                pc <= redirect_pc;
            end
        end
    end

    assign issue_pc = pc;

    // misaligned fetch wins over a pending interrupt
    always_comb begin
        if (pc[1:0] != 2'b00) begin
            issue_cause = CAUSE_ADEF;
        end else if (irq && irq_en) begin
            issue_cause = CAUSE_INT;
        end else begin
            issue_cause = CAUSE_NONE;
        end
    end

    // one instruction in flight at a time
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !issue)
        else $error("pc_reg issued while an instruction is in flight");

endmodule

// ==== source/fe_if.sv ====
`timescale 1ns/1ps

// decode to execute, one strobe per instruction
interface dec_if
    import fe_pkg::*;
();
    logic     valid;
    addr_t    pc;
    op_t      op;
    // already sign extended
    addr_t    offset;
    operand_t cmp_a;
    operand_t cmp_b;
    // ADEF or INT when the word was never fetched
    cause_t   pre_cause;

    modport src (output valid, pc, op, offset, cmp_a, cmp_b, pre_cause);
    modport dst (input valid, pc, op, offset, cmp_a, cmp_b, pre_cause);
endinterface

// execute to result, one strobe per instruction
interface exe_if
    import fe_pkg::*;
();
    logic   valid;
    addr_t  pc;
    // resolved fall-through or branch target
    addr_t  next_pc;
    cause_t cause;
    logic   is_ertn;

    modport src (output valid, pc, next_pc, cause, is_ertn);
    modport dst (input valid, pc, next_pc, cause, is_ertn);
endinterface

// ==== source/fe_pkg.sv ====
package fe_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths with a meaning
    //////////////////////////////////////////////////////////////////////

    // instruction address
    typedef logic [31:0] addr_t;

    // instruction word
    // [31:28] opcode, [25:0] signed byte offset
    // compare splits the low bits into [25:13] and [12:0]
    typedef logic [31:0] inst_t;

    // raw opcode field of the word
    typedef logic [3:0] opc_t;

    // one compare operand
    typedef logic [12:0] operand_t;

    // exception cause code
    typedef logic [5:0] cause_t;

    //////////////////////////////////////////////////////////////////////
    // decoded operations
    //////////////////////////////////////////////////////////////////////

    // encodings match the opcode field, anything else is illegal
    typedef enum logic [3:0] {
        OP_SEQ     = 4'h0,
        OP_B       = 4'h1,
        OP_BF      = 4'h2,
        OP_CMP     = 4'h3,
        OP_SYSCALL = 4'h4,
        OP_ERTN    = 4'h5,
        OP_ILL     = 4'hF
    } op_t;

    //////////////////////////////////////////////////////////////////////
    // cause codes
    //////////////////////////////////////////////////////////////////////

    localparam cause_t CAUSE_INT  = 6'h00;
    localparam cause_t CAUSE_ADEF = 6'h08;
    localparam cause_t CAUSE_SYS  = 6'h0B;
    localparam cause_t CAUSE_INE  = 6'h0D;
    // no exception
    localparam cause_t CAUSE_NONE = 6'h3F;

endpackage
